// File: Makefile
SRCS := $(shell grep -v '^+' flist.f)

.PHONY: all run clean

all: obj_dir/Vtb_exc_top

obj_dir/Vtb_exc_top: flist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_exc_top -f flist.f -o Vtb_exc_top

run: obj_dir/Vtb_exc_top bench/exc_stimulus.txt
	obj_dir/Vtb_exc_top > sim.log 2>&1
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/exc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exc_checker (
    input wire                       clk,
    input wire                       arst_n,
    input wire                       in_valid,
    input wire exc_pkg::credit_cnt_t in_credit,
    input wire                       res_credit,
    input wire                       res_valid,
    input wire exc_pkg::word_t       res_pc,
    input wire exc_pkg::word_t       res_value,
    input wire                       exc_valid,
    input wire exc_pkg::word_t       exc_pc,
    input wire exc_pkg::exc_code_t   exc_code,
    input wire                       flush,
    input wire exc_pkg::word_t       redirect_pc,
    input wire exc_pkg::word_t       cp0_epc,
    input wire exc_pkg::word_t       cp0_badvaddr,
    input wire                       cp0_exl
);

    typedef struct packed {
        int          line;
        int          kind;  // 0 result, 1 exception, 2 eret, 3 squashed
        logic [31:0] pc;
        logic [31:0] value; // result, cause code or new pc
        logic [31:0] bad;
    } exp_t;

    exp_t exp_q[$];
    exp_t dropped[$];
    exp_t trap;      // waits one cycle for cp0
    bit   post_pending;
    bit   post_ok;
    int   pass_cnt;
    int   fail_cnt;
    int   flush_cnt;
    int   in_out;
    int   res_out;

    task automatic add_expect(input int line, kind, input logic [31:0] pc, value, bad);
        exp_t e;
        e.line  = line;
        e.kind  = kind;
        e.pc    = pc;
        e.value = value;
        e.bad   = bad;
        exp_q.push_back(e);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    function automatic bit same(input string name, input logic [31:0] expv, actv);
        if (expv === actv)
            return 1'b1;
        $display("error %0t %s expected %h actual %h", $time, name, expv, actv);
        return 1'b0;
    endfunction

    task automatic close_test(input int line, input bit ok, input string note);
        if (ok) begin
            pass_cnt++;
            $display("test %0d: pass %s", line, note);
        end else begin
            fail_cnt++;
            $display("test %0d: fail %s", line, note);
        end
    endtask

    task automatic note_skip(input int line);
        close_test(line, 1'b1, "(not issued, flush came first)");
    endtask

    task automatic report_dropped();
        exp_t e;
        while (dropped.size() != 0) begin
            e = dropped.pop_front();
            if (e.kind != 3)
                $display("report for test %0d was lost in a flush", e.line);
            close_test(e.line, e.kind == 3, "(squashed)");
        end
    endtask

    task automatic print_summary();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    endtask

    always @(negedge clk) begin
        exp_t e;
        bit   ok;
        if (arst_n) begin
            in_out  += int'(in_valid) - int'(in_credit);
            res_out += int'(res_valid || exc_valid) - int'(res_credit);
            if (in_out > exc_pkg::IN_CREDITS || in_out < 0) begin
                $display("source holds %0d instructions outstanding at %0t", in_out, $time);
                fail_cnt++;
            end
            if (res_out > exc_pkg::RES_CREDITS) begin
                $display("DUT sent %0d reports beyond the sink credits at %0t", res_out, $time);
                fail_cnt++;
            end
            if (post_pending) begin
                ok = post_ok;
                ok &= same("cp0_exl", (trap.kind == 1) ? 32'd1 : 32'd0, 32'(cp0_exl));
                if (trap.kind == 1 && (trap.value == 32'(exc_pkg::EX_ADEL) ||
                                       trap.value == 32'(exc_pkg::EX_ADES)))
                    ok &= same("cp0_badvaddr", trap.bad, cp0_badvaddr);
                if (trap.kind == 1)
                    ok &= same("cp0_epc", trap.pc, cp0_epc);
                close_test(trap.line, ok, (trap.kind == 1) ? "(exception)" : "(eret)");
                post_pending = 1'b0;
                report_dropped();
            end
            if (res_valid || exc_valid) begin
                if (exp_q.size() == 0) begin
                    $display("report at %0t with no instruction outstanding", $time);
                    fail_cnt++;
                end else begin
                    e  = exp_q.pop_front();
                    ok = 1'b1;
                    case (e.kind)
                        0: begin
                            ok &= same("res_valid", 32'd1, 32'(res_valid));
                            ok &= same("res_pc", e.pc, res_pc);
                            ok &= same("res_value", e.value, res_value);
                            ok &= same("flush", 32'd0, 32'(flush));
                        end
                        1: begin
                            ok &= same("exc_valid", 32'd1, 32'(exc_valid));
                            ok &= same("exc_pc", e.pc, exc_pc);
                            ok &= same("exc_code", e.value, 32'(exc_code));
                            ok &= same("flush", 32'd1, 32'(flush));
                            ok &= same("redirect_pc", exc_pkg::EXC_VECTOR, redirect_pc);
                        end
                        2: begin
                            ok &= same("res_valid", 32'd1, 32'(res_valid));
                            ok &= same("res_pc", e.pc, res_pc);
                            ok &= same("res_value", e.value, res_value);
                            ok &= same("flush", 32'd1, 32'(flush));
                            ok &= same("redirect_pc", e.value, redirect_pc);
                        end
                        default: begin
                            $display("test %0d was reported though an older trap flushed it",
                                     e.line);
                            ok = 1'b0;
                        end
                    endcase
                    if (e.kind == 1 || e.kind == 2) begin
                        trap         = e;
                        post_ok      = ok;
                        post_pending = 1'b1;
                    end else begin
                        close_test(e.line, ok, "(result)");
                    end
                end
            end
            if (flush) begin
                flush_cnt++;
                while (exp_q.size() != 0)
                    dropped.push_back(exp_q.pop_front()); // younger than the trap
                if (!post_pending)
                    report_dropped();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/exc_stimulus.txt
# pc instr op_a op_b int_lines kind value badvaddr (hex, kind decimal)
# kind 0 result value, 1 exception code, 2 eret new pc, 3 squashed by an older trap
00400000 012A4020 00000005 00000007 00 0 0000000C 00000000
00400004 012A4021 FFFFFFFF 00000002 00 0 00000001 00000000
00400008 012A4021 7FFFFFFF 00000001 00 0 80000000 00000000
0040000C 8D280010 10000000 00000000 00 0 10000010 00000000
00400010 AD28FFFC 10000008 00000000 00 0 10000004 00000000
00400014 012A4020 7FFFFFFF 00000001 00 1 0000000C 00000000
00400018 012A4020 00000001 00000001 00 3 00000000 00000000
0040001C 012A4021 00000001 00000001 00 3 00000000 00000000
BFC00380 42000018 00000000 00000000 00 2 00400014 00000000
BFC00384 012A4020 00000001 00000001 00 3 00000000 00000000
00400014 012A4021 7FFFFFFF 00000001 00 0 80000000 00000000
00400018 8D280000 10000001 00000000 00 1 00000004 10000001
BFC00380 AD280000 10000002 00000000 00 1 00000005 10000002
BFC00380 0000000C 00000000 00000000 00 1 00000008 00000000
BFC00380 0000000D 00000000 00000000 00 1 00000009 00000000
BFC00380 7C000000 00000000 00000000 00 1 0000000A 00000000
BFC00380 42000018 00000000 00000000 00 2 BFC00380 00000000
BFC00380 012A4020 00000001 00000002 01 1 00000000 00000000
BFC00380 012A4021 00000001 00000001 01 0 00000002 00000000
BFC00384 42000018 00000000 00000000 00 2 BFC00380 00000000
BFC00380 012A4020 00000003 00000004 00 0 00000007 00000000
0040001E 0000000C 00000000 00000000 00 1 00000004 0040001E
00400022 012A4020 00000001 00000001 00 3 00000000 00000000
BFC00380 012A4021 00000005 00000006 00 0 0000000B 00000000

// File: bench/tb_exc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exc_top;

    localparam int TIMEOUT = 200; // cycles per wait loop

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    exc_pkg::word_t       in_pc;
    exc_pkg::word_t       in_instr;
    exc_pkg::word_t       in_op_a;
    exc_pkg::word_t       in_op_b;
    exc_pkg::credit_cnt_t in_credit;
    logic                 res_credit;
    logic [5:0]           int_lines;
    logic                 res_valid;
    exc_pkg::word_t       res_pc;
    exc_pkg::word_t       res_value;
    logic                 exc_valid;
    exc_pkg::word_t       exc_pc;
    exc_pkg::exc_code_t   exc_code;
    logic                 flush;
    exc_pkg::word_t       redirect_pc;
    exc_pkg::word_t       cp0_epc;
    exc_pkg::word_t       cp0_badvaddr;
    logic                 cp0_exl;

    int                   credits; // input credits held by the source
    int                   owed;    // reports not yet credited back
    bit                   aborted;
    logic [15:0]          lfsr;

    exc_top exc_top_inst (.*);

    exc_checker exc_checker_inst (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
    endfunction

    // every clock advance of the source goes through here
    task automatic tick();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        credits += int'(in_credit);
    endtask

    task automatic wait_credit();
        int n;
        n = 0;
        while (credits == 0 && !aborted) begin
            tick();
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: the DUT returned no input credit");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_flush(input int mark);
        int n;
        n = 0;
        while (exc_checker_inst.flush_cnt == mark && !aborted) begin
            tick();
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: an exception or eret never raised flush");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exc_checker_inst.pending_count() != 0 && !aborted) begin
            tick();
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: issued instructions were never reported");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic drive(input exc_pkg::word_t pc, instr, a, b);
        in_valid = 1'b1;
        in_pc    = pc;
        in_instr = instr;
        in_op_a  = a;
        in_op_b  = b;
        credits--;
    endtask

    // sink hands back one credit per report after random gaps
    initial begin
        res_credit = 1'b0;
        owed       = 0;
        lfsr       = 16'd59718;
        forever begin
            @(posedge clk);
            #1;
            res_credit = 1'b0;
            if (res_valid || exc_valid)
                owed++;
            if (owed > 0) begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0]) begin
                    res_credit = 1'b1;
                    owed--;
                end
            end
        end
    end

    initial begin
        int             fd;
        string          text;
        int             line_no;
        int             kind;
        int             trap_mark;
        bit             trap_open;
        exc_pkg::word_t pc;
        exc_pkg::word_t instr;
        exc_pkg::word_t a;
        exc_pkg::word_t b;
        exc_pkg::word_t value;
        exc_pkg::word_t bad;
        logic [5:0]     irq;

        in_valid  = 1'b0;
        in_pc     = '0;
        in_instr  = '0;
        in_op_a   = '0;
        in_op_b   = '0;
        int_lines = '0;
        arst_n    = 1'b0;
        aborted   = 1'b0;
        trap_open = 1'b0;
        trap_mark = 0;
        line_no   = 0;
        repeat (3) @(posedge clk);
        #1;
        arst_n  = 1'b1;
        credits = exc_pkg::IN_CREDITS;

        fd = $fopen("bench/exc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/exc_stimulus.txt");
            aborted = 1'b1;
        end
        while (!aborted && fd != 0 && !$feof(fd)) begin
            if ($fgets(text, fd) == 0)
                continue;
            if (text.len() < 8 || text[0] == "#")
                continue;
            line_no++;
            if ($sscanf(text, "%h %h %h %h %h %d %h %h",
                        pc, instr, a, b, irq, kind, value, bad) != 8) begin
                $display("stimulus test %0d is malformed", line_no);
                aborted = 1'b1;
                continue;
            end
            if (kind == 3) begin
                // younger than a trap, only sent while the flush is still ahead
                tick();
                wait_credit();
                if (trap_open && exc_checker_inst.flush_cnt == trap_mark && !aborted) begin
                    exc_checker_inst.add_expect(line_no, kind, pc, value, bad);
                    drive(pc, instr, a, b);
                end else begin
                    exc_checker_inst.note_skip(line_no);
                end
            end else begin
                if (trap_open)
                    wait_flush(trap_mark);
                trap_open = 1'b0;
                if (irq != '0)
                    drain(); // interrupt must hit this instruction only
                tick();
                wait_credit();
                if (!aborted) begin
                    trap_mark = exc_checker_inst.flush_cnt;
                    int_lines = irq;
                    exc_checker_inst.add_expect(line_no, kind, pc, value, bad);
                    drive(pc, instr, a, b);
                end
                trap_open = (kind == 1 || kind == 2);
                if (irq != '0) begin
                    drain();
                    int_lines = '0;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        drain();
        repeat (3) tick(); // cp0 follow-up checks
        exc_checker_inst.print_summary();
        if (aborted || exc_checker_inst.fail_cnt != 0)
            $display("STATUS: FAIL");
        else
            $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/exc_pkg.sv
hdl/exc_decode.sv
hdl/exc_execute.sv
hdl/exc_commit.sv
hdl/cp0_regs.sv
hdl/exc_top.sv
bench/exc_checker.sv
bench/tb_exc_top.sv

// File: hdl/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     exc_we,
    input  wire exc_pkg::exc_code_t exc_code,
    input  wire exc_pkg::word_t     epc_val,
    input  wire                     bad_we,
    input  wire exc_pkg::word_t     bad_val,
    input  wire                     eret_we,
    output logic                    exl,
    output exc_pkg::word_t          epc,
    output exc_pkg::word_t          badvaddr,
    output exc_pkg::exc_code_t      cause_code
);

    // only exl of status is kept and ie reads as 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            exl <= 1'b0;
        else if (exc_we)
            exl <= 1'b1;
        else if (eret_we)
            exl <= 1'b0;
    end

    // cause and epc latch together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cause_code <= '0;
            epc        <= '0;
        end else if (exc_we) begin
            cause_code <= exc_code;
            epc        <= epc_val;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            badvaddr <= '0;
        else if (bad_we)
            badvaddr <= bad_val; // address errors only
    end

endmodule

`default_nettype wire

// File: hdl/exc_commit.sv
`timescale 1ns/1ps
`default_nettype none

module exc_commit (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  x_valid,
    input  wire exc_pkg::word_t  x_pc,
    input  wire exc_pkg::word_t  x_value,
    input  wire                  x_ovf,
    input  wire                  x_data_ade,
    input  wire                  x_data_store,
    input  wire                  x_sys,
    input  wire                  x_bp,
    input  wire                  x_eret,
    input  wire                  x_ri,
    input  wire                  x_fetch_ade,
    input  wire [5:0]            int_lines,
    input  wire                  res_credit,
    input  wire                  exl,
    input  wire exc_pkg::word_t  epc,
    output logic                 stall,
    output logic                 flush,
    output exc_pkg::word_t       redirect_pc,
    output logic                 res_valid,
    output exc_pkg::word_t       res_pc,
    output exc_pkg::word_t       res_value,
    output logic                 exc_valid,
    output exc_pkg::word_t       exc_pc,
    output exc_pkg::exc_code_t   exc_code,
    output logic                 exc_we,
    output exc_pkg::word_t       epc_val,
    output logic                 bad_we,
    output exc_pkg::word_t       bad_val,
    output logic                 eret_we
);

    exc_pkg::credit_cnt_t credits;
    exc_pkg::exc_code_t   code;
    exc_pkg::word_t       bad_addr;
    exc_pkg::word_t       report_pc;
    logic                 take;
    logic                 int_req;
    logic                 is_exc;
    logic                 bad_sel;

    assign stall   = x_valid && (credits == '0);
    assign take    = x_valid && !stall && !flush; // younger op is dying during flush
    assign int_req = (int_lines != '0) && !exl;

    assign res_pc  = report_pc;
    assign exc_pc  = report_pc;
    assign epc_val = report_pc;
    assign exc_we  = exc_valid;

    // fixed priority, first match wins
    always_comb begin
        is_exc   = 1'b1;
        bad_sel  = 1'b0;
        bad_addr = x_pc;
        code     = exc_pkg::EX_INT;
        if (int_req) begin
            code = exc_pkg::EX_INT;
        end else if (x_fetch_ade) begin
            code    = exc_pkg::EX_ADEL;
            bad_sel = 1'b1;
        end else if (x_ri) begin
            code = exc_pkg::EX_RI;
        end else if (x_sys) begin
            code = exc_pkg::EX_SYS;
        end else if (x_bp) begin
            code = exc_pkg::EX_BP;
        end else if (x_ovf) begin
            code = exc_pkg::EX_OV;
        end else if (x_data_ade) begin
            code     = x_data_store ? exc_pkg::EX_ADES : exc_pkg::EX_ADEL;
            bad_sel  = 1'b1;
            bad_addr = x_value;
        end else begin
            is_exc = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            exc_valid <= 1'b0;
            flush     <= 1'b0;
            bad_we    <= 1'b0;
            eret_we   <= 1'b0;
            credits   <= exc_pkg::credit_cnt_t'(exc_pkg::RES_CREDITS);
        end else begin
            res_valid <= take && !is_exc;
            exc_valid <= take && is_exc;
            flush     <= take && (is_exc || x_eret);
            bad_we    <= take && bad_sel;
            eret_we   <= take && !is_exc && x_eret;
            credits   <= credits - exc_pkg::credit_cnt_t'(take)
                         + exc_pkg::credit_cnt_t'(res_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            report_pc   <= x_pc;
            res_value   <= x_eret ? epc : x_value; // eret reports its new pc
            exc_code    <= code;
            bad_val     <= bad_addr;
            redirect_pc <= is_exc ? exc_pkg::EXC_VECTOR : epc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exc_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exc_decode (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        in_valid,
    input  wire exc_pkg::word_t        in_pc,
    input  wire exc_pkg::word_t        in_instr,
    input  wire exc_pkg::word_t        in_op_a,
    input  wire exc_pkg::word_t        in_op_b,
    input  wire                        stall,
    input  wire                        flush,
    output exc_pkg::credit_cnt_t       in_credit,
    output logic                       d_valid,
    output exc_pkg::word_t             d_pc,
    output exc_pkg::word_t             d_op_a,
    output exc_pkg::word_t             d_op_b,
    output exc_pkg::word_t             d_imm,
    output logic                       d_add,
    output logic                       d_addu,
    output logic                       d_lw,
    output logic                       d_sw,
    output logic                       d_sys,
    output logic                       d_bp,
    output logic                       d_eret,
    output logic                       d_ri,
    output logic                       d_fetch_ade
);

    localparam int QW = $clog2(exc_pkg::IN_CREDITS);

    exc_pkg::word_t       q_pc    [exc_pkg::IN_CREDITS];
    exc_pkg::word_t       q_instr [exc_pkg::IN_CREDITS];
    exc_pkg::word_t       q_op_a  [exc_pkg::IN_CREDITS];
    exc_pkg::word_t       q_op_b  [exc_pkg::IN_CREDITS];
    logic [QW-1:0]        wr_ptr;
    logic [QW-1:0]        rd_ptr;
    exc_pkg::credit_cnt_t count;
    logic                 push;
    logic                 pop;
    exc_pkg::word_t       h_instr;
    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic                 c_add, c_addu, c_lw, c_sw, c_sys, c_bp, c_eret;

    assign push    = in_valid && !flush;
    assign pop     = (count != '0) && !stall && !flush;
    assign h_instr = q_instr[rd_ptr];
    assign opcode  = h_instr[31:26];
    assign funct   = h_instr[5:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= '0;
        end else if (flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= count + exc_pkg::credit_cnt_t'(in_valid); // dropped plus late arrival
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count + exc_pkg::credit_cnt_t'(push) - exc_pkg::credit_cnt_t'(pop);
            in_credit <= exc_pkg::credit_cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_ptr]    <= in_pc;
            q_instr[wr_ptr] <= in_instr;
            q_op_a[wr_ptr]  <= in_op_a;
            q_op_b[wr_ptr]  <= in_op_b;
        end
    end

    always_comb begin
        c_add  = 1'b0;
        c_addu = 1'b0;
        c_lw   = 1'b0;
        c_sw   = 1'b0;
        c_sys  = 1'b0;
        c_bp   = 1'b0;
        c_eret = 1'b0;
        case (opcode)
            exc_pkg::OP_SPECIAL: begin
                c_add  = funct == exc_pkg::FN_ADD;
                c_addu = funct == exc_pkg::FN_ADDU;
                c_sys  = funct == exc_pkg::FN_SYSCALL;
                c_bp   = funct == exc_pkg::FN_BREAK;
            end
            exc_pkg::OP_LW:   c_lw = 1'b1;
            exc_pkg::OP_SW:   c_sw = 1'b1;
            exc_pkg::OP_COP0: c_eret = h_instr[25] && funct == exc_pkg::FN_ERET; // co bit
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            d_valid <= 1'b0;
        else if (flush)
            d_valid <= 1'b0;
        else if (!stall)
            d_valid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            d_pc        <= q_pc[rd_ptr];
            d_op_a      <= q_op_a[rd_ptr];
            d_op_b      <= q_op_b[rd_ptr];
            d_imm       <= {{16{h_instr[15]}}, h_instr[15:0]};
            d_add       <= c_add;
            d_addu      <= c_addu;
            d_lw        <= c_lw;
            d_sw        <= c_sw;
            d_sys       <= c_sys;
            d_bp        <= c_bp;
            d_eret      <= c_eret;
            d_ri        <= !(c_add || c_addu || c_lw || c_sw || c_sys || c_bp || c_eret);
            d_fetch_ade <= q_pc[rd_ptr][1:0] != 2'b00;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exc_execute.sv
`timescale 1ns/1ps
`default_nettype none

module exc_execute (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 stall,
    input  wire                 flush,
    input  wire                 d_valid,
    input  wire exc_pkg::word_t d_pc,
    input  wire exc_pkg::word_t d_op_a,
    input  wire exc_pkg::word_t d_op_b,
    input  wire exc_pkg::word_t d_imm,
    input  wire                 d_add,
    input  wire                 d_addu,
    input  wire                 d_lw,
    input  wire                 d_sw,
    input  wire                 d_sys,
    input  wire                 d_bp,
    input  wire                 d_eret,
    input  wire                 d_ri,
    input  wire                 d_fetch_ade,
    output logic                x_valid,
    output exc_pkg::word_t      x_pc,
    output exc_pkg::word_t      x_value,
    output logic                x_ovf,
    output logic                x_data_ade,
    output logic                x_data_store,
    output logic                x_sys,
    output logic                x_bp,
    output logic                x_eret,
    output logic                x_ri,
    output logic                x_fetch_ade
);

    exc_pkg::word_t sum_ab;
    exc_pkg::word_t sum_ai;
    exc_pkg::word_t value;
    logic           mem;
    logic           ovf;

    assign sum_ab = d_op_a + d_op_b;
    assign sum_ai = d_op_a + d_imm; // effective address
    assign mem    = d_lw || d_sw;
    assign value  = (d_add || d_addu) ? sum_ab : (mem ? sum_ai : '0);

    // operands agree in sign, sum does not
    assign ovf = d_add && (d_op_a[31] == d_op_b[31]) && (sum_ab[31] != d_op_a[31]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            x_valid <= 1'b0;
        else if (flush)
            x_valid <= 1'b0;
        else if (!stall)
            x_valid <= d_valid;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            x_pc         <= d_pc;
            x_value      <= value;
            x_ovf        <= ovf;
            x_data_ade   <= mem && (sum_ai[1:0] != 2'b00);
            x_data_store <= d_sw;
            x_sys        <= d_sys;
            x_bp         <= d_bp;
            x_eret       <= d_eret;
            x_ri         <= d_ri;
            x_fetch_ade  <= d_fetch_ade;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exc_pkg.sv
`default_nettype none

package exc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [1:0]  credit_cnt_t;

    // major opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // funct field, instr[5:0]
    localparam logic [5:0] FN_SYSCALL = 6'h0C;
    localparam logic [5:0] FN_BREAK   = 6'h0D;
    localparam logic [5:0] FN_ERET    = 6'h18;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;

    // cp0 cause codes
    localparam exc_code_t EX_INT  = 5'd0;
    localparam exc_code_t EX_ADEL = 5'd4;
    localparam exc_code_t EX_ADES = 5'd5;
    localparam exc_code_t EX_SYS  = 5'd8;
    localparam exc_code_t EX_BP   = 5'd9;
    localparam exc_code_t EX_RI   = 5'd10;
    localparam exc_code_t EX_OV   = 5'd12;

    localparam word_t BOOT_BASE  = 32'hBFC0_0200;
    localparam word_t EXC_VECTOR = BOOT_BASE + 32'h0000_0180; // general exception entry

    localparam int IN_CREDITS  = 2; // decode queue depth
    localparam int RES_CREDITS = 2; // sink slots

endpackage

`default_nettype wire

// File: hdl/exc_top.sv
`timescale 1ns/1ps
`default_nettype none

module exc_top (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        in_valid,
    input  wire exc_pkg::word_t        in_pc,
    input  wire exc_pkg::word_t        in_instr,
    input  wire exc_pkg::word_t        in_op_a,
    input  wire exc_pkg::word_t        in_op_b,
    output exc_pkg::credit_cnt_t       in_credit,
    input  wire                        res_credit,
    input  wire [5:0]                  int_lines,
    output logic                       res_valid,
    output exc_pkg::word_t             res_pc,
    output exc_pkg::word_t             res_value,
    output logic                       exc_valid,
    output exc_pkg::word_t             exc_pc,
    output exc_pkg::exc_code_t         exc_code,
    output logic                       flush,
    output exc_pkg::word_t             redirect_pc,
    output exc_pkg::word_t             cp0_epc,
    output exc_pkg::word_t             cp0_badvaddr,
    output logic                       cp0_exl
);

    logic           stall;
    logic           d_valid;
    exc_pkg::word_t d_pc, d_op_a, d_op_b, d_imm;
    logic           d_add, d_addu, d_lw, d_sw, d_sys, d_bp, d_eret, d_ri, d_fetch_ade;
    logic           x_valid;
    exc_pkg::word_t x_pc, x_value;
    logic           x_ovf, x_data_ade, x_data_store;
    logic           x_sys, x_bp, x_eret, x_ri, x_fetch_ade;
    logic           exc_we, bad_we, eret_we;
    exc_pkg::word_t epc_val, bad_val;

    exc_decode exc_decode_inst (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_pc(in_pc), .in_instr(in_instr),
        .in_op_a(in_op_a), .in_op_b(in_op_b),
        .stall(stall), .flush(flush), .in_credit(in_credit),
        .d_valid(d_valid), .d_pc(d_pc), .d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
        .d_add(d_add), .d_addu(d_addu), .d_lw(d_lw), .d_sw(d_sw), .d_sys(d_sys),
        .d_bp(d_bp), .d_eret(d_eret), .d_ri(d_ri), .d_fetch_ade(d_fetch_ade)
    );

    exc_execute exc_execute_inst (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush),
        .d_valid(d_valid), .d_pc(d_pc), .d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
        .d_add(d_add), .d_addu(d_addu), .d_lw(d_lw), .d_sw(d_sw), .d_sys(d_sys),
        .d_bp(d_bp), .d_eret(d_eret), .d_ri(d_ri), .d_fetch_ade(d_fetch_ade),
        .x_valid(x_valid), .x_pc(x_pc), .x_value(x_value), .x_ovf(x_ovf),
        .x_data_ade(x_data_ade), .x_data_store(x_data_store),
        .x_sys(x_sys), .x_bp(x_bp), .x_eret(x_eret), .x_ri(x_ri), .x_fetch_ade(x_fetch_ade)
    );

    exc_commit exc_commit_inst (
        .clk(clk), .arst_n(arst_n),
        .x_valid(x_valid), .x_pc(x_pc), .x_value(x_value), .x_ovf(x_ovf),
        .x_data_ade(x_data_ade), .x_data_store(x_data_store),
        .x_sys(x_sys), .x_bp(x_bp), .x_eret(x_eret), .x_ri(x_ri), .x_fetch_ade(x_fetch_ade),
        .int_lines(int_lines), .res_credit(res_credit), .exl(cp0_exl), .epc(cp0_epc),
        .stall(stall), .flush(flush), .redirect_pc(redirect_pc),
        .res_valid(res_valid), .res_pc(res_pc), .res_value(res_value),
        .exc_valid(exc_valid), .exc_pc(exc_pc), .exc_code(exc_code),
        .exc_we(exc_we), .epc_val(epc_val), .bad_we(bad_we), .bad_val(bad_val),
        .eret_we(eret_we)
    );

    cp0_regs cp0_regs_inst (
        .clk(clk), .arst_n(arst_n),
        .exc_we(exc_we), .exc_code(exc_code), .epc_val(epc_val),
        .bad_we(bad_we), .bad_val(bad_val), .eret_we(eret_we),
        .exl(cp0_exl), .epc(cp0_epc), .badvaddr(cp0_badvaddr),
        .cause_code() // not brought out at the top
    );

endmodule

`default_nettype wire
